// File: noc_axis_top.f
hdl/noc_pkg.sv
hdl/flit_serializer.sv
hdl/flit_crossbar.sv
hdl/flit_deserializer.sv
hdl/noc_axis_top.sv
verif/noc_assert.sv
verif/noc_checker.sv
verif/tb_noc_axis_top.sv

// File: verif/tb_noc_axis_top.sv
`timescale 1ns/1ps

module tb_noc_axis_top import noc_pkg::*; ();

  localparam int NUM_BEATS = 200;
  localparam int MAX_CYCLES = NUM_BEATS * FLITS_PER_BEAT * N_PORTS * 4;

  logic      CLK;
  logic      rst;
  axis_in_t  in_beat   [N_PORTS];
  logic      in_valid  [N_PORTS];
  logic      in_ready  [N_PORTS];
  axis_out_t out_beat  [N_PORTS];
  logic      out_valid [N_PORTS];
  logic      out_ready [N_PORTS];

  integer seed;
  int     cycles;
  int     sent [N_PORTS];
  logic   took [N_PORTS];            // Beat accepted on the last rising edge
  int     tb_errors;
  int     chk_errors;
  int     beats_pending;
  int     block_port;
  int     block_left;
  int     assert_fails;
  logic   timed_out;

  noc_axis_top u_noc_axis_top (.*);

  noc_checker u_checker (
    .CLK, .rst,
    .in_beat, .in_valid, .in_ready,
    .out_beat, .out_valid, .out_ready,
    .errors  (chk_errors    ),
    .pending (beats_pending )
  );

  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    for (int p = 0; p < N_PORTS; p++) begin
      took[p] <= in_valid[p] && in_ready[p];
      if (in_valid[p] && in_ready[p]) begin
        sent[p] <= sent[p] + 1;
      end
    end
  end

  // ####################
  // Stimulus
  // ####################
  task automatic drive_inputs();
    for (int p = 0; p < N_PORTS; p++) begin
      if (!in_valid[p] || took[p]) begin  // Hold an offered beat until taken
        if (sent[p] < NUM_BEATS && ($unsigned($random(seed)) % 100) < 70) begin
          in_valid[p]      = 1'b1;
          in_beat[p].data  = $random(seed);
          in_beat[p].dest  = PORT_W'($random(seed));
          in_beat[p].last  = 1'($random(seed));
        end else begin
          in_valid[p] = 1'b0;
        end
      end
    end
  endtask

  task automatic set_back_pressure();
    if (block_left > 0) begin
      block_left--;
    end else if (cycles % 400 == 50) begin
      block_port = (cycles / 400) % N_PORTS;  // One port stalls for a while
      block_left = 100;
    end
    for (int p = 0; p < N_PORTS; p++) begin
      if (block_left > 0 && block_port == p) begin
        out_ready[p] = 1'b0;
      end else begin
        out_ready[p] = ($unsigned($random(seed)) % 100) < 80;
      end
    end
  endtask

  task automatic check_reset_state();
    for (int p = 0; p < N_PORTS; p++) begin
      if (in_ready[p] !== 1'b1) begin
        tb_errors++;
        $display("[ERROR] %0t: in_ready not high on port %0d after reset", $time, p);
      end
      if (out_valid[p] !== 1'b0) begin
        tb_errors++;
        $display("[ERROR] %0t: out_valid not low on port %0d after reset", $time, p);
      end
    end
  endtask

  function automatic logic all_delivered();
    logic done;
    done = (beats_pending == 0);
    for (int p = 0; p < N_PORTS; p++) begin
      if (sent[p] < NUM_BEATS || in_valid[p]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // ####################
  // Main sequence
  // ####################
  initial begin
    seed       = 32'h8c55_56c8;
    CLK        = 1'b0;
    rst        = 1'b1;
    cycles     = 0;
    tb_errors  = 0;
    block_port = 0;
    block_left = 0;
    timed_out  = 1'b0;
    for (int p = 0; p < N_PORTS; p++) begin
      in_beat[p]   = '0;
      in_valid[p]  = 1'b0;
      out_ready[p] = 1'b0;
      sent[p]      = 0;
      took[p]      = 1'b0;
    end
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    rst = 1'b0;
    check_reset_state();

    while (!all_delivered() && cycles < MAX_CYCLES) begin
      drive_inputs();
      set_back_pressure();
      @(negedge CLK);
      cycles++;
    end

    if (cycles >= MAX_CYCLES) begin
      timed_out = 1'b1;
      $display("Timeout: traffic did not drain within %0d cycles", MAX_CYCLES);
    end
    if (beats_pending != 0) begin
      tb_errors++;
      $display("%0d sent beats never reached their destination", beats_pending);
    end
    assert_fails = u_noc_axis_top.u_xbar.u_assert.fail_count;
    $display("Checker errors: %0d, testbench errors: %0d, assertion failures: %0d",
             chk_errors, tb_errors, assert_fails);
    if (chk_errors + tb_errors + assert_fails == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verif/noc_checker.sv
`timescale 1ns/1ps

module noc_checker import noc_pkg::*; (
  input  logic      CLK,
  input  logic      rst,

  input  axis_in_t  in_beat   [N_PORTS],
  input  logic      in_valid  [N_PORTS],
  input  logic      in_ready  [N_PORTS],

  input  axis_out_t out_beat  [N_PORTS],
  input  logic      out_valid [N_PORTS],
  input  logic      out_ready [N_PORTS],

  output int        errors,
  output int        pending
);

  typedef logic [DATA_W:0] exp_t;  // {data, last}

  // One queue per (source, destination) pair
  exp_t exp_q [N_PORTS*N_PORTS][$];

  initial begin
    errors  = 0;
    pending = 0;
  end

  task automatic check_beat(input int d, input axis_out_t b);
    int   idx;
    exp_t exp;
    idx = b.id * N_PORTS + d;
    if (exp_q[idx].size() == 0) begin
      errors++;
      $display("[ERROR] %0t: port %0d delivered a beat from source %0d that was never sent",
               $time, d, b.id);
    end else begin
      exp = exp_q[idx].pop_front();
      pending--;
      if (exp != {b.data, b.last}) begin
        errors++;
        $display("[ERROR] %0t: port %0d from source %0d expected data %h last %b, got %h last %b",
                 $time, d, b.id, exp[DATA_W:1], exp[0], b.data, b.last);
      end
    end
  endtask

  // ####################
  // Scoreboard
  // ####################
  always @(posedge CLK) begin
    if (!rst) begin
      for (int s = 0; s < N_PORTS; s++) begin
        if (in_valid[s] && in_ready[s]) begin
          exp_q[s * N_PORTS + in_beat[s].dest].push_back({in_beat[s].data, in_beat[s].last});
          pending++;
        end
      end
      for (int d = 0; d < N_PORTS; d++) begin
        if (out_valid[d] && out_ready[d]) begin
          check_beat(d, out_beat[d]);
        end
      end
    end
  end

endmodule

// File: verif/noc_assert.sv
`timescale 1ns/1ps

module noc_assert import noc_pkg::*; (
  input logic                CLK,
  input logic                rst,
  input lock_state_e         lock_state    [N_PORTS],
  input logic [PORT_W-1:0]   locked_in     [N_PORTS],
  input logic [CREDIT_W-1:0] credit        [N_PORTS],
  input flit_t               ser_flit      [N_PORTS],
  input logic                ser_valid     [N_PORTS],
  input logic                ser_ready     [N_PORTS],
  input logic                xbar_valid    [N_PORTS],
  input flit_t               xbar_flit     [N_PORTS],
  input logic                credit_return [N_PORTS]
);

  int                 fail_count = 0;
  logic [N_PORTS-1:0] taken     [N_PORTS];  // Per output, one bit per input whose flit moved
  int                 in_flight [N_PORTS];  // Flits sitting in each output buffer

  always_comb begin
    for (int o = 0; o < N_PORTS; o++) begin
      for (int i = 0; i < N_PORTS; i++) begin
        taken[o][i] = ser_valid[i] && ser_ready[i] && (ser_flit[i].dest == PORT_W'(o));
      end
    end
  end

  always @(posedge CLK) begin
    for (int o = 0; o < N_PORTS; o++) begin
      if (rst) begin
        in_flight[o] <= 0;
      end else begin
        in_flight[o] <= in_flight[o] + int'(xbar_valid[o]) - int'(credit_return[o]);
      end
    end
  end

  for (genvar o = 0; o < N_PORTS; o++) begin : g_out
    a_one_grant: assert property (@(posedge CLK) disable iff (rst) $onehot0(taken[o]))
      else begin
        fail_count++;
        $error("Output %0d granted more than one input", o);
      end

    // Flit may only arrive while the output buffer has a free slot
    a_credit_used: assert property (@(posedge CLK) disable iff (rst)
      xbar_valid[o] |-> (in_flight[o] - int'(credit_return[o])) < FLIT_BUF_DEPTH)
      else begin
        fail_count++;
        $error("Output %0d sent a flit without credit", o);
      end

    a_credit_max: assert property (@(posedge CLK) disable iff (rst)
      credit[o] <= CREDIT_W'(FLIT_BUF_DEPTH))
      else begin
        fail_count++;
        $error("Output %0d credit counter above buffer depth", o);
      end

    a_locked_src: assert property (@(posedge CLK) disable iff (rst)
      (xbar_valid[o] && $past(lock_state[o] == OUT_LOCKED))
        |-> xbar_flit[o].src == $past(locked_in[o]))
      else begin
        fail_count++;
        $error("Output %0d forwarded a flit from an input it is not locked to", o);
      end
  end

endmodule

bind flit_crossbar noc_assert u_assert (
  .CLK           (CLK           ),
  .rst           (rst           ),
  .lock_state    (lock_state    ),
  .locked_in     (locked_in     ),
  .credit        (credit        ),
  .ser_flit      (ser_flit      ),
  .ser_valid     (ser_valid     ),
  .ser_ready     (ser_ready     ),
  .xbar_valid    (xbar_valid    ),
  .xbar_flit     (xbar_flit     ),
  .credit_return (credit_return )
);

// File: hdl/noc_axis_top.sv
`timescale 1ns/1ps

module noc_axis_top import noc_pkg::*; (
  input  logic      CLK,
  input  logic      rst,

  input  axis_in_t  in_beat   [N_PORTS],
  input  logic      in_valid  [N_PORTS],
  output logic      in_ready  [N_PORTS],

  output axis_out_t out_beat  [N_PORTS],
  output logic      out_valid [N_PORTS],
  input  logic      out_ready [N_PORTS]
);

  flit_t ser_flit      [N_PORTS];
  logic  ser_valid     [N_PORTS];
  logic  ser_ready     [N_PORTS];
  flit_t xbar_flit     [N_PORTS];
  logic  xbar_valid    [N_PORTS];
  logic  credit_return [N_PORTS];

  // ####################
  // Endpoints
  // ####################
  for (genvar p = 0; p < N_PORTS; p++) begin : g_port
    flit_serializer #(
      .SRC_ID (PORT_W'(p))   // Source number of this endpoint
    ) u_ser (
      .CLK,
      .rst,
      .in_beat   (in_beat[p]   ),
      .in_valid  (in_valid[p]  ),
      .in_ready  (in_ready[p]  ),
      .ser_flit  (ser_flit[p]  ),
      .ser_valid (ser_valid[p] ),
      .ser_ready (ser_ready[p] )
    );

    flit_deserializer u_deser (
      .CLK,
      .rst,
      .xbar_flit     (xbar_flit[p]     ),
      .xbar_valid    (xbar_valid[p]    ),
      .credit_return (credit_return[p] ),
      .out_beat      (out_beat[p]      ),
      .out_valid     (out_valid[p]     ),
      .out_ready     (out_ready[p]     )
    );
  end

  // Network
  flit_crossbar u_xbar (
    .CLK,
    .rst,
    .ser_flit,
    .ser_valid,
    .ser_ready,
    .xbar_flit,
    .xbar_valid,
    .credit_return
  );

endmodule

// File: hdl/flit_deserializer.sv
`timescale 1ns/1ps

module flit_deserializer import noc_pkg::*; (
  input  logic      CLK,
  input  logic      rst,

  input  flit_t     xbar_flit,
  input  logic      xbar_valid,
  output logic      credit_return,

  output axis_out_t out_beat,
  output logic      out_valid,
  input  logic      out_ready
);

  flit_t                 buf_mem [FLIT_BUF_DEPTH];
  logic [BUF_PTR_W-1:0]  wr_ptr;
  logic [BUF_PTR_W-1:0]  rd_ptr;
  logic [CREDIT_W-1:0]   count;
  flit_t                 head;
  logic                  pop;

  logic [FLIT_IDX_W-1:0] asm_idx;
  axis_out_t             asm_q;

  assign head = buf_mem[rd_ptr];

  // Finished beat leaving this cycle frees the assembly register
  assign pop           = (count != '0) && (!out_valid || out_ready);
  assign credit_return = pop;
  assign out_beat      = asm_q;

  // ####################
  // Flit buffer
  // ####################
  always_ff @(posedge CLK) begin
    if (xbar_valid) begin
      buf_mem[wr_ptr] <= xbar_flit;  // Credits keep this from overflowing
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + BUF_PTR_W'(xbar_valid);
      rd_ptr <= rd_ptr + BUF_PTR_W'(pop);
      count  <= count + CREDIT_W'(xbar_valid) - CREDIT_W'(pop);
    end
  end

  // ####################
  // Beat assembly
  // ####################
  always_ff @(posedge CLK) begin
    if (rst) begin
      asm_idx   <= '0;
      out_valid <= 1'b0;
    end else begin
      if (pop) begin
        asm_idx <= head.tail ? '0 : asm_idx + 1'b1;
      end
      if (pop && head.tail) begin
        out_valid <= 1'b1;
      end else if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (pop) begin
      asm_q.data[asm_idx*FLIT_DATA_W +: FLIT_DATA_W] <= head.payload;
      if (head.tail) begin
        asm_q.id   <= head.src;
        asm_q.last <= head.last;
      end
    end
  end

endmodule

// File: hdl/flit_crossbar.sv
`timescale 1ns/1ps

module flit_crossbar import noc_pkg::*; (
  input  logic  CLK,
  input  logic  rst,

  input  flit_t ser_flit      [N_PORTS],
  input  logic  ser_valid     [N_PORTS],
  output logic  ser_ready     [N_PORTS],

  output flit_t xbar_flit     [N_PORTS],
  output logic  xbar_valid    [N_PORTS],

  input  logic  credit_return [N_PORTS]
);

  // Per output state
  lock_state_e         lock_state [N_PORTS];
  logic [PORT_W-1:0]   locked_in  [N_PORTS];
  logic [PORT_W-1:0]   rr_ptr     [N_PORTS];
  logic [CREDIT_W-1:0] credit     [N_PORTS];

  // Per output, one bit per input
  logic [N_PORTS-1:0]  req        [N_PORTS];
  logic [N_PORTS-1:0]  grant      [N_PORTS];
  logic [PORT_W-1:0]   sel        [N_PORTS];
  logic                fwd        [N_PORTS];

  always_comb begin
    for (int o = 0; o < N_PORTS; o++) begin
      for (int i = 0; i < N_PORTS; i++) begin
        req[o][i] = ser_valid[i] && (ser_flit[i].dest == PORT_W'(o));
      end
    end
  end

  // ####################
  // Arbitration
  // ####################
  always_comb begin : arb
    logic [PORT_W-1:0] cand;
    logic              found;
    for (int i = 0; i < N_PORTS; i++) begin
      ser_ready[i] = 1'b0;
    end
    for (int o = 0; o < N_PORTS; o++) begin
      found  = 1'b0;
      cand   = '0;
      sel[o] = locked_in[o];
      if (lock_state[o] == OUT_FREE) begin
        sel[o] = rr_ptr[o];
        // Search starts just after the last winner
        for (int k = 1; k <= N_PORTS; k++) begin
          cand = rr_ptr[o] + PORT_W'(k);
          if (!found && req[o][cand]) begin
            sel[o] = cand;
            found  = 1'b1;
          end
        end
      end
      for (int i = 0; i < N_PORTS; i++) begin
        grant[o][i] = req[o][i] && (sel[o] == PORT_W'(i));
      end
      fwd[o] = (|grant[o]) && (credit[o] != '0);
      for (int i = 0; i < N_PORTS; i++) begin
        if (grant[o][i] && credit[o] != '0) begin
          ser_ready[i] = 1'b1;
        end
      end
    end
  end

  // ####################
  // Wormhole lock and pointer
  // ####################
  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int o = 0; o < N_PORTS; o++) begin
        lock_state[o] <= OUT_FREE;
        locked_in[o]  <= '0;
        rr_ptr[o]     <= PORT_W'(N_PORTS - 1);  // Input 0 wins first
      end
    end else begin
      for (int o = 0; o < N_PORTS; o++) begin
        if (fwd[o]) begin
          if (ser_flit[sel[o]].tail) begin
            lock_state[o] <= OUT_FREE;
            rr_ptr[o]     <= sel[o];
          end else begin
            lock_state[o] <= OUT_LOCKED;
            locked_in[o]  <= sel[o];
          end
        end
      end
    end
  end

  // Credits, one per free flit slot downstream
  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int o = 0; o < N_PORTS; o++) begin
        credit[o] <= CREDIT_W'(FLIT_BUF_DEPTH);
      end
    end else begin
      for (int o = 0; o < N_PORTS; o++) begin
        credit[o] <= credit[o] - CREDIT_W'(fwd[o]) + CREDIT_W'(credit_return[o]);
      end
    end
  end

  // ####################
  // Output registers
  // ####################
  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int o = 0; o < N_PORTS; o++) begin
        xbar_valid[o] <= 1'b0;
      end
    end else begin
      for (int o = 0; o < N_PORTS; o++) begin
        xbar_valid[o] <= fwd[o];
      end
    end
  end

  always_ff @(posedge CLK) begin
    for (int o = 0; o < N_PORTS; o++) begin
      if (fwd[o]) begin
        xbar_flit[o] <= ser_flit[sel[o]];
      end
    end
  end

endmodule

// File: hdl/flit_serializer.sv
`timescale 1ns/1ps

module flit_serializer import noc_pkg::*; #(
  parameter logic [PORT_W-1:0] SRC_ID = '0
) (
  input  logic      CLK,
  input  logic      rst,

  input  axis_in_t  in_beat,
  input  logic      in_valid,
  output logic      in_ready,

  output flit_t     ser_flit,
  output logic      ser_valid,
  input  logic      ser_ready
);

  ser_state_e            state;
  axis_in_t              beat_q;
  logic [FLIT_IDX_W-1:0] flit_idx;
  logic                  last_idx;

  assign in_ready  = (state == SER_IDLE);
  assign ser_valid = (state == SER_SEND);
  assign last_idx  = (flit_idx == FLIT_IDX_W'(FLITS_PER_BEAT - 1));

  // Beat register, loaded only while idle
  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      beat_q <= in_beat;
    end
  end

  // ####################
  // Flit walk
  // ####################
  always_ff @(posedge CLK) begin
    if (rst) begin
      state    <= SER_IDLE;
      flit_idx <= '0;
    end else begin
      case (state)
        SER_IDLE: begin
          if (in_valid) begin
            state    <= SER_SEND;
            flit_idx <= '0;
          end
        end
        SER_SEND: begin
          if (ser_ready) begin
            if (last_idx) begin
              state <= SER_IDLE;
            end
            flit_idx <= flit_idx + 1'b1;
          end
        end
        default: state <= SER_IDLE;
      endcase
    end
  end

  always_comb begin
    ser_flit.tail    = last_idx;
    ser_flit.dest    = beat_q.dest;
    ser_flit.src     = SRC_ID;
    ser_flit.last    = beat_q.last;
    ser_flit.payload = beat_q.data[flit_idx*FLIT_DATA_W +: FLIT_DATA_W];  // LSB first
  end

endmodule

// File: hdl/noc_pkg.sv
package noc_pkg;

  // ####################
  // Sizes
  // ####################
  localparam int N_PORTS        = 4;
  localparam int PORT_W         = 2;
  localparam int DATA_W         = 32;
  localparam int FLIT_DATA_W    = 8;
  localparam int FLITS_PER_BEAT = DATA_W / FLIT_DATA_W;
  localparam int FLIT_IDX_W     = 2;
  localparam int FLIT_BUF_DEPTH = 4;               // Also the initial credit count
  localparam int BUF_PTR_W      = $clog2(FLIT_BUF_DEPTH);
  localparam int CREDIT_W       = 3;

  // ####################
  // Stream beats
  // ####################
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [PORT_W-1:0] dest;
    logic              last;
  } axis_in_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [PORT_W-1:0] id;                         // Source port of the beat
    logic              last;
  } axis_out_t;

  // One byte of a beat, least significant byte first
  typedef struct packed {
    logic                   tail;
    logic [PORT_W-1:0]      dest;
    logic [PORT_W-1:0]      src;
    logic                   last;
    logic [FLIT_DATA_W-1:0] payload;
  } flit_t;

  // ####################
  // States
  // ####################
  typedef enum logic {
    SER_IDLE,
    SER_SEND
  } ser_state_e;

  typedef enum logic {
    OUT_FREE,
    OUT_LOCKED
  } lock_state_e;

endpackage
